//--- bench/mmu_checker.sv
// Watches the MMU ports, predicts every translation from the page tables in the
// testbench memory and reports each request as a test of its own
`timescale 1ns/1ps
`default_nettype none

module mmu_checker (
	input wire clk,
	input wire rst,
	input wire flush,
	input wire [31:0] ptbr,
	input wire vadr_v,
	input wire [31:0] vadr,
	input wire store,
	input wire [7:0] asid,
	input wire busy,
	input wire [31:0] padr,
	input wire padr_v,
	input wire page_fault,
	input wire mem_req,
	input wire [31:0] mem_adr
);

	int pass_count = 0;
	int fail_count = 0;
	int edges;
	int reads;
	int kind;
	int exp_reads;
	bit active = 0;
	bit prev_req = 0;
	bit ok;
	bit cached;
	logic [31:0] va_q;
	logic st_q;
	logic [7:0] asid_q;
	logic [31:0] exp_padr;
	logic [31:0] exp_adr;
	string name;

	// Expected contents of the direct-mapped TLB, indexed by the low page number bits
	bit model_v [16];
	logic [19:0] model_vpn [16];
	logic [7:0] model_asid [16];

	// Returns 0 for a translation, 1 for an invalid directory entry, 2 for an
	// invalid leaf entry and 3 for a store without write permission
	function automatic int ref_translate(input logic [31:0] base, input logic [31:0] va,
			input logic st, output logic [31:0] pa);
		logic [31:0] dir_pte;
		logic [31:0] leaf_pte;
		pa = 32'h0;
		dir_pte = mmu_tb.read_word(base + {20'h0, va[31:22], 2'b00});
		if (!dir_pte[0])
			return 1;
		leaf_pte = mmu_tb.read_word({dir_pte[31:12], 12'h0} + {20'h0, va[21:12], 2'b00});
		if (!leaf_pte[0])
			return 2;
		if (st && !leaf_pte[1])
			return 3;
		pa = {leaf_pte[31:12], va[11:0]};
		return 0;
	endfunction

	// Address of the n-th memory read of a walk: directory entry first, then leaf entry
	function automatic logic [31:0] walk_adr(input logic [31:0] base, input logic [31:0] va,
			input int n);
		logic [31:0] dir_adr;
		logic [31:0] dir_pte;
		dir_adr = base + {20'h0, va[31:22], 2'b00};
		dir_pte = mmu_tb.read_word(dir_adr);
		if (n == 0)
			return dir_adr;
		return {dir_pte[31:12], 12'h0} + {20'h0, va[21:12], 2'b00};
	endfunction

	always @(posedge clk) begin
		// A flush taken while idle drops every entry
		if (rst || (flush && !busy))
			foreach (model_v[i])
				model_v[i] = 1'b0;
		if (rst) begin
			active = 0;
		end else if (active && (padr_v || page_fault)) begin
			kind = ref_translate(ptbr, va_q, st_q, exp_padr);
			if (kind == 0 && !(padr_v && !page_fault && padr === exp_padr)) begin
				$display("[ERROR] %s: expected padr %h, actual padr %h padr_v %b page_fault %b",
					name, exp_padr, padr, padr_v, page_fault);
				ok = 0;
			end
			if (kind != 0 && !(page_fault && !padr_v)) begin
				$display("[ERROR] %s: expected page_fault 1, actual page_fault %b padr_v %b",
					name, page_fault, padr_v);
				ok = 0;
			end
			if (busy !== 1'b0) begin
				$display("[ERROR] %s: expected busy 0 in the result cycle, actual %b",
					name, busy);
				ok = 0;
			end
			// Without a fixed count a cached page costs no reads and a walk stops
			// at the first invalid entry
			if (exp_reads < 0)
				exp_reads = (kind == 1) ? 1 : (kind == 2) ? 2 : cached ? 0 : 2;
			if (reads != exp_reads) begin
				$display("[ERROR] %s: expected %0d memory reads, actual %0d",
					name, exp_reads, reads);
				ok = 0;
			end
			if (exp_reads == 0 && edges != 2) begin
				$display("[ERROR] %s: expected hit latency 2 edges, actual %0d", name, edges);
				ok = 0;
			end
			// Every valid leaf lands in the TLB, whether the access is allowed or not
			if (kind == 0 || kind == 3) begin
				model_v[va_q[15:12]] = 1'b1;
				model_vpn[va_q[15:12]] = va_q[31:12];
				model_asid[va_q[15:12]] = asid_q;
			end
			if (ok)
				pass_count++;
			else
				fail_count++;
			$display("%s %s", ok ? "[PASS]" : "[FAIL]", name);
			active = 0;
		end else if (active) begin
			if (busy !== 1'b1 && ok) begin
				$display("[ERROR] %s: expected busy 1 while translating, actual %b",
					name, busy);
				ok = 0;
			end
			if (mem_req && !prev_req) begin
				exp_adr = walk_adr(ptbr, va_q, reads);
				if (mem_adr !== exp_adr) begin
					$display("[ERROR] %s: expected mem_adr %h, actual %h",
						name, exp_adr, mem_adr);
					ok = 0;
				end
				reads++;
			end
			edges++;
		end else if (vadr_v && !busy && !padr_v && !page_fault) begin
			va_q = vadr;
			st_q = store;
			asid_q = asid;
			cached = model_v[vadr[15:12]] && model_vpn[vadr[15:12]] == vadr[31:12]
				&& model_asid[vadr[15:12]] == asid;
			name = mmu_tb.test_name;
			exp_reads = mmu_tb.exp_reads;
			edges = 1;
			reads = 0;
			ok = 1;
			active = 1;
		end
		prev_req = mem_req;
	end

	task automatic print_summary();
		$display("summary: %0d requests correct, %0d wrong", pass_count, fail_count);
	endtask

endmodule

`default_nettype wire

//--- bench/mmu_tb.sv
// Testbench for the MMU with a page table memory that acknowledges after a random delay
// Runs directed walk, fault, permission, ASID and flush requests, then a random mix
`timescale 1ns/1ps
`default_nettype none

module mmu_tb;

	localparam logic [31:0] PTBR = 32'h0001_0000;
	localparam int RESULT_TIMEOUT = 200;

	logic clk;
	logic rst;
	logic flush;
	logic [31:0] ptbr;
	logic vadr_v;
	logic [31:0] vadr;
	logic store;
	logic [7:0] asid;
	logic [31:0] padr;
	logic padr_v;
	logic page_fault;
	logic busy;
	logic mem_req;
	logic [31:0] mem_adr;
	logic [31:0] mem_rdata = 32'h0;
	logic mem_ack = 1'b0;

	logic [31:0] mem_words [logic [31:0]];
	string test_name = "";
	int exp_reads = -1;
	int requests = 0;
	int ack_wait = 0;
	bit timed_out = 0;

	mmu_top mmu_top_inst (.*);
	mmu_checker checker_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==================================================
	// Page table memory
	// ==================================================
	function automatic logic [31:0] read_word(input logic [31:0] adr);
		return mem_words.exists(adr) ? mem_words[adr] : 32'h0;
	endfunction

	always @(negedge clk) begin
		mem_ack = 1'b0;
		if (mem_req && ack_wait == 0)
			ack_wait = $urandom_range(1, 5);
		if (ack_wait > 0) begin
			ack_wait--;
			if (ack_wait == 0) begin
				mem_ack = 1'b1;
				mem_rdata = read_word(mem_adr);
			end
		end
	end

	// Directories 0 to 3 are valid, leaf 7 of each table is invalid and odd leaves are writable
	task automatic build_page_tables();
		logic [19:0] leaf_ppn;
		for (int d = 0; d < 4; d++) begin
			leaf_ppn = 20'h00020 + 20'(d);
			mem_words[PTBR + 32'(d * 4)] = {leaf_ppn, 10'h0, 1'b0, 1'b1};
			for (int l = 0; l < 16; l++)
				mem_words[{leaf_ppn, 12'h0} + 32'(l * 4)] =
					{20'h80000 + 20'(d * 64 + l * 5), 10'h0, 1'(l % 2), l != 7};
		end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	function automatic logic [31:0] page_va(input int dir, input int leaf, input logic [11:0] ofs);
		return {10'(dir), 10'(leaf), ofs};
	endfunction

	task automatic run_request(input string name, input logic [31:0] va, input logic st,
			input logic [7:0] id, input int reads);
		int waited;
		if (!timed_out) begin
			@(negedge clk);
			test_name = name;
			exp_reads = reads;
			vadr = va;
			store = st;
			asid = id;
			vadr_v = 1'b1;
			requests++;
			@(negedge clk);
			vadr_v = 1'b0;
			waited = 0;
			while (!padr_v && !page_fault && waited < RESULT_TIMEOUT) begin
				@(negedge clk);
				waited++;
			end
			if (!padr_v && !page_fault) begin
				$display("timeout: no translation result for %s within %0d cycles",
					name, RESULT_TIMEOUT);
				timed_out = 1;
			end
		end
	endtask

	task automatic pulse_flush();
		if (!timed_out) begin
			@(negedge clk);
			flush = 1'b1;
			@(negedge clk);
			flush = 1'b0;
		end
	endtask

	initial begin
		void'($urandom(24));
		rst = 1'b1;
		flush = 1'b0;
		ptbr = PTBR;
		vadr_v = 1'b0;
		vadr = 32'h0;
		store = 1'b0;
		asid = 8'h0;
		build_page_tables();
		repeat (2) @(negedge clk);
		rst = 1'b0;

		run_request("walk_first", page_va(0, 1, 12'h123), 1'b0, 8'd1, 2);
		run_request("walk_hit", page_va(0, 1, 12'h456), 1'b0, 8'd1, 0);
		run_request("dir_fault", page_va(4, 0, 12'h010), 1'b0, 8'd1, 1);
		run_request("leaf_fault", page_va(0, 7, 12'h020), 1'b0, 8'd1, 2);
		run_request("load_read_only", page_va(0, 2, 12'h030), 1'b0, 8'd1, 2);
		run_request("store_read_only", page_va(0, 2, 12'h034), 1'b1, 8'd1, 0);
		run_request("store_writable", page_va(0, 3, 12'h040), 1'b1, 8'd1, 2);
		run_request("asid_first", page_va(1, 4, 12'h050), 1'b0, 8'd1, 2);
		run_request("asid_other", page_va(1, 4, 12'h054), 1'b0, 8'd2, 2);
		run_request("flush_first", page_va(2, 5, 12'h060), 1'b0, 8'd3, 2);
		run_request("flush_cached", page_va(2, 5, 12'h064), 1'b0, 8'd3, 0);
		pulse_flush();
		run_request("flush_rewalk", page_va(2, 5, 12'h068), 1'b0, 8'd3, 2);

		for (int i = 0; i < 200; i++)
			run_request($sformatf("random_%0d", i),
				page_va($urandom_range(0, 4), $urandom_range(0, 15), 12'($urandom)),
				1'($urandom_range(0, 1)), 8'($urandom_range(0, 3)), -1);

		repeat (2) @(negedge clk);
		checker_inst.print_summary();
		if (!timed_out && checker_inst.fail_count == 0 && checker_inst.pass_count == requests)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the MMU testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module mmu_tb -o mmu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/mmu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "test passed"; then
	exit 0
fi
exit 1

//--- src.f
+incdir+src
src/mmu_pkg.sv
src/walk_if.sv
src/tlb.sv
src/page_table_walker.sv
src/mmu_top.sv
bench/mmu_checker.sv
bench/mmu_tb.sv

//--- src/mmu_defs.svh
// Size definitions for the MMU, built for a single configuration
// Include this wherever an address, page or TLB width is needed
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// ==================================================
// Address and page geometry
// ==================================================
`define MMU_VA_BITS     32
`define MMU_PAGE_BITS   12
`define MMU_INDEX_BITS  10
`define MMU_VPN_BITS    (`MMU_VA_BITS - `MMU_PAGE_BITS)

// ==================================================
// TLB geometry
// ==================================================
`define MMU_TLB_BITS    4
`define MMU_TLB_ENTRIES (1 << `MMU_TLB_BITS)
`define MMU_TAG_BITS    (`MMU_VPN_BITS - `MMU_TLB_BITS)
`define MMU_ASID_BITS   8

`endif

//--- src/mmu_pkg.sv
// Shared types for the MMU: page table entries, TLB entries and FSM states
// Referenced by scoped name from the TLB and the walker
`default_nettype none

`include "mmu_defs.svh"

package mmu_pkg;

	// One memory word; directory entries share this layout and ignore w
	typedef struct packed {
		logic [`MMU_VPN_BITS-1:0] ppn;
		logic [`MMU_VA_BITS-`MMU_VPN_BITS-3:0] rsvd;
		logic w;
		logic v;
	} pte_t;

	typedef struct packed {
		logic v;
		logic [`MMU_ASID_BITS-1:0] asid;
		logic [`MMU_TAG_BITS-1:0] tag;
		logic [`MMU_VPN_BITS-1:0] ppn;
		logic w;
	} tlb_entry_t;

	typedef enum logic [1:0] {tlb_idle, tlb_check, tlb_wait_fill} tlb_state_t;

	typedef enum logic [2:0] {
		walk_idle, walk_read_dir, walk_wait_dir,
		walk_read_leaf, walk_wait_leaf, walk_done
	} walk_state_t;

endpackage

`default_nettype wire

//--- src/mmu_top.sv
// MMU top level: the TLB and the page table walker on plain ports
// The memory port serves the walker's page table reads only
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module mmu_top (
	input wire clk,
	input wire rst,
	input wire flush,
	input wire [`MMU_VA_BITS-1:0] ptbr,
	input wire vadr_v,
	input wire [`MMU_VA_BITS-1:0] vadr,
	input wire store,
	input wire [`MMU_ASID_BITS-1:0] asid,
	output logic [`MMU_VA_BITS-1:0] padr,
	output logic padr_v,
	output logic page_fault,
	output logic busy,
	output logic mem_req,
	output logic [`MMU_VA_BITS-1:0] mem_adr,
	input wire [31:0] mem_rdata,
	input wire mem_ack
);

	walk_if walk_bus ();

	tlb tlb_inst (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.vadr_v(vadr_v),
		.vadr(vadr),
		.store(store),
		.asid(asid),
		.padr(padr),
		.padr_v(padr_v),
		.page_fault(page_fault),
		.busy(busy),
		.walk(walk_bus.tlb)
	);

	page_table_walker walker_inst (
		.clk(clk),
		.rst(rst),
		.ptbr(ptbr),
		.mem_rdata(mem_rdata),
		.mem_ack(mem_ack),
		.mem_req(mem_req),
		.mem_adr(mem_adr),
		.walk(walk_bus.walker)
	);

endmodule

`default_nettype wire

//--- src/page_table_walker.sv
// Two-level hardware page table walker
// Reads the directory entry and then the leaf entry, and answers each miss
// with a fill or a fault
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module page_table_walker (
	input wire clk,
	input wire rst,
	input wire [`MMU_VA_BITS-1:0] ptbr,
	input wire mmu_pkg::pte_t mem_rdata,
	input wire mem_ack,
	output logic mem_req,
	output logic [`MMU_VA_BITS-1:0] mem_adr,
	walk_if.walker walk
);

	mmu_pkg::walk_state_t state;

	// Last entry read, directory or leaf
	mmu_pkg::pte_t pte_q;

	logic [`MMU_VA_BITS-1:0] dir_ofs;
	logic [`MMU_VA_BITS-1:0] leaf_ofs;
	logic [`MMU_VA_BITS-1:0] leaf_base;

	// Word offsets into each table from the two halves of the page number
	assign dir_ofs = {{(`MMU_VA_BITS - `MMU_INDEX_BITS - 2){1'b0}},
		walk.miss_vpn[`MMU_VPN_BITS-1:`MMU_INDEX_BITS], 2'b00};
	assign leaf_ofs = {{(`MMU_VA_BITS - `MMU_INDEX_BITS - 2){1'b0}},
		walk.miss_vpn[`MMU_INDEX_BITS-1:0], 2'b00};

	// The directory entry names the page holding the leaf table
	assign leaf_base = {pte_q.ppn, {`MMU_PAGE_BITS{1'b0}}};

	assign walk.fill_ppn = pte_q.ppn;
	assign walk.fill_w = pte_q.w;

	// ==================================================
	// Address and entry capture
	// ==================================================
	always_ff @(posedge clk) begin
		case (state)
		mmu_pkg::walk_read_dir: mem_adr <= ptbr + dir_ofs;
		mmu_pkg::walk_read_leaf: mem_adr <= leaf_base + leaf_ofs;
		mmu_pkg::walk_wait_dir,
		mmu_pkg::walk_wait_leaf: begin
			if (mem_ack)
				pte_q <= mem_rdata;
		end
		default: ;
		endcase
	end

	// ==================================================
	// Walk FSM
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mmu_pkg::walk_idle;
			mem_req <= 1'b0;
			walk.fill <= 1'b0;
			walk.fault <= 1'b0;
		end else begin
			walk.fill <= 1'b0;
			walk.fault <= 1'b0;
			case (state)
			mmu_pkg::walk_idle: begin
				if (walk.miss)
					state <= mmu_pkg::walk_read_dir;
			end
			mmu_pkg::walk_read_dir: begin
				mem_req <= 1'b1;
				state <= mmu_pkg::walk_wait_dir;
			end
			mmu_pkg::walk_wait_dir: begin
				// An invalid directory entry skips the leaf read
				if (mem_ack) begin
					mem_req <= 1'b0;
					if (mem_rdata.v)
						state <= mmu_pkg::walk_read_leaf;
					else
						state <= mmu_pkg::walk_done;
				end
			end
			mmu_pkg::walk_read_leaf: begin
				mem_req <= 1'b1;
				state <= mmu_pkg::walk_wait_leaf;
			end
			mmu_pkg::walk_wait_leaf: begin
				if (mem_ack) begin
					mem_req <= 1'b0;
					state <= mmu_pkg::walk_done;
				end
			end
			mmu_pkg::walk_done: begin
				// pte_q is a valid leaf or whichever entry ended the walk
				if (pte_q.v)
					walk.fill <= 1'b1;
				else
					walk.fault <= 1'b1;
				state <= mmu_pkg::walk_idle;
			end
			default: state <= mmu_pkg::walk_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/tlb.sv
// Direct-mapped TLB with ASID tags, write permission check and flush
// Misses go out over walk_if and the held request is checked again after a fill
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module tlb (
	input wire clk,
	input wire rst,
	input wire flush,
	input wire vadr_v,
	input wire [`MMU_VA_BITS-1:0] vadr,
	input wire store,
	input wire [`MMU_ASID_BITS-1:0] asid,
	output logic [`MMU_VA_BITS-1:0] padr,
	output logic padr_v,
	output logic page_fault,
	output logic busy,
	walk_if.tlb walk
);

	mmu_pkg::tlb_state_t state;
	mmu_pkg::tlb_entry_t tlb_mem [`MMU_TLB_ENTRIES];
	mmu_pkg::tlb_entry_t entry;

	logic [`MMU_VPN_BITS-1:0] req_vpn;
	logic [`MMU_PAGE_BITS-1:0] req_ofs;
	logic [`MMU_ASID_BITS-1:0] req_asid;
	logic req_store;
	logic [`MMU_TLB_BITS-1:0] idx;
	logic [`MMU_TAG_BITS-1:0] tag;
	logic accept;
	logic hit;

	// A new request is taken only when idle and not presenting a result
	assign accept = (state == mmu_pkg::tlb_idle) && vadr_v && !padr_v && !page_fault;
	assign busy = (state != mmu_pkg::tlb_idle);

	assign idx = req_vpn[`MMU_TLB_BITS-1:0];
	assign tag = req_vpn[`MMU_VPN_BITS-1:`MMU_TLB_BITS];
	assign entry = tlb_mem[idx];
	assign hit = entry.v && (entry.tag == tag) && (entry.asid == req_asid);

	assign walk.miss_vpn = req_vpn;

	// ==================================================
	// Request and result payload
	// ==================================================
	always_ff @(posedge clk) begin
		if (accept) begin
			req_vpn <= vadr[`MMU_VA_BITS-1:`MMU_PAGE_BITS];
			req_ofs <= vadr[`MMU_PAGE_BITS-1:0];
			req_asid <= asid;
			req_store <= store;
		end
		if (state == mmu_pkg::tlb_check && hit)
			padr <= {entry.ppn, req_ofs};
	end

	// ==================================================
	// FSM and entry array
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mmu_pkg::tlb_idle;
			padr_v <= 1'b0;
			page_fault <= 1'b0;
			walk.miss <= 1'b0;
			for (int i = 0; i < `MMU_TLB_ENTRIES; i++)
				tlb_mem[i].v <= 1'b0;
		end else begin
			padr_v <= 1'b0;
			page_fault <= 1'b0;
			walk.miss <= 1'b0;
			case (state)
			mmu_pkg::tlb_idle: begin
				if (flush)
					for (int i = 0; i < `MMU_TLB_ENTRIES; i++)
						tlb_mem[i].v <= 1'b0;
				if (accept)
					state <= mmu_pkg::tlb_check;
			end
			mmu_pkg::tlb_check: begin
				if (hit) begin
					// Stores need the w bit of the leaf entry
					if (req_store && !entry.w)
						page_fault <= 1'b1;
					else
						padr_v <= 1'b1;
					state <= mmu_pkg::tlb_idle;
				end else begin
					walk.miss <= 1'b1;
					state <= mmu_pkg::tlb_wait_fill;
				end
			end
			mmu_pkg::tlb_wait_fill: begin
				if (walk.fill) begin
					tlb_mem[idx] <= '{v: 1'b1, asid: req_asid, tag: tag,
						ppn: walk.fill_ppn, w: walk.fill_w};
					state <= mmu_pkg::tlb_check;
				end else if (walk.fault) begin
					page_fault <= 1'b1;
					state <= mmu_pkg::tlb_idle;
				end
			end
			default: state <= mmu_pkg::tlb_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/walk_if.sv
// Miss and refill path between the TLB and the page table walker
// The TLB raises a miss; the walker answers with exactly one fill or fault
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

interface walk_if;

	// Miss is a single-cycle pulse, miss_vpn stays put until the answer
	logic miss;
	logic [`MMU_VPN_BITS-1:0] miss_vpn;

	// Fill and fault are single-cycle pulses
	logic fill;
	logic [`MMU_VPN_BITS-1:0] fill_ppn;
	logic fill_w;
	logic fault;

	modport tlb (output miss, miss_vpn, input fill, fill_ppn, fill_w, fault);
	modport walker (input miss, miss_vpn, output fill, fill_ppn, fill_w, fault);

endinterface

`default_nettype wire
